//--- list.f
rtl/exe_pkg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/csr_unit.sv
rtl/int_prf.sv
rtl/exe.sv
rtl/int_exe_cluster.sv
test/tb_int_exe_cluster.sv

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                      ex0_valid,
    input  exe_pkg::t_uop             uop,
    input  logic [exe_pkg::XLEN-1:0]  src1,
    input  logic [exe_pkg::XLEN-1:0]  src2,
    input  logic [exe_pkg::XLEN-1:0]  imm,
    input  logic [exe_pkg::XLEN-1:0]  pc,
    input  logic                      pred_taken,
    input  logic [exe_pkg::XLEN-1:0]  pred_target,
    output logic                      resvld,
    output logic [exe_pkg::XLEN-1:0]  result,
    output logic                      mispred,
    output logic [exe_pkg::XLEN-1:0]  mispred_target,
    output logic                      train_valid,
    output logic                      train_taken,
    output logic [exe_pkg::XLEN-1:0]  train_target
);

    logic                     is_br;
    logic                     is_jump;
    logic                     taken;
    logic [exe_pkg::XLEN-1:0] target;
    logic [exe_pkg::XLEN-1:0] link;
    logic                     wrong_dir;
    logic                     wrong_tgt;

    always_comb begin
        is_br   = 1'b1;
        is_jump = 1'b0;
        taken   = 1'b0;
        case (uop)
            exe_pkg::U_BEQ:  taken = src1 == src2;
            exe_pkg::U_BNE:  taken = src1 != src2;
            exe_pkg::U_BLT:  taken = $signed(src1) < $signed(src2);
            exe_pkg::U_BGE:  taken = $signed(src1) >= $signed(src2);
            exe_pkg::U_BLTU: taken = src1 < src2;
            exe_pkg::U_BGEU: taken = src1 >= src2;
            exe_pkg::U_JAL, exe_pkg::U_JALR: begin
                is_jump = 1'b1;
                taken   = 1'b1;
            end
            default: is_br = 1'b0;
        endcase
    end

    // JALR is register relative with bit 0 dropped
    always_comb begin
        if (uop == exe_pkg::U_JALR) begin
            target = (src1 + imm) & ~{{(exe_pkg::XLEN-1){1'b0}}, 1'b1};
        end else begin
            target = pc + imm;
        end
        link = pc + exe_pkg::XLEN'(4);
    end

    always_comb begin
        wrong_dir      = taken != pred_taken;
        wrong_tgt      = taken & pred_taken & (target != pred_target);
        mispred        = ex0_valid & is_br & (wrong_dir | wrong_tgt);
        mispred_target = taken ? target : link;
        train_valid    = ex0_valid & is_br;
        train_taken    = taken;
        train_target   = target;
        resvld         = ex0_valid & is_jump;
        result         = link;
    end

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ex0_valid,
    input  logic                            kill,
    input  exe_pkg::t_uop                   uop,
    input  logic [exe_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  logic [exe_pkg::XLEN-1:0]        src1,
    output logic                            resvld,
    output logic [exe_pkg::XLEN-1:0]        result
);

    logic [exe_pkg::XLEN-1:0]       scratch [exe_pkg::CSR_NUM_SCRATCH];
    logic [exe_pkg::CSR_ADDR_W-1:0] offset;
    logic [exe_pkg::CSR_IDX_W-1:0]  idx;
    logic                           hit;
    logic                           is_csr;
    logic                           wr_en;
    logic [exe_pkg::XLEN-1:0]       old_val;
    logic [exe_pkg::XLEN-1:0]       new_val;

    always_comb begin
        offset  = csr_addr - exe_pkg::CSR_SCRATCH_BASE;
        hit     = offset < exe_pkg::CSR_ADDR_W'(exe_pkg::CSR_NUM_SCRATCH);
        idx     = offset[exe_pkg::CSR_IDX_W-1:0];
        old_val = hit ? scratch[idx] : '0;
        is_csr  = 1'b1;
        case (uop)
            exe_pkg::U_CSRRW: new_val = src1;
            exe_pkg::U_CSRRS: new_val = old_val | src1;
            exe_pkg::U_CSRRC: new_val = old_val & ~src1;
            default: begin
                is_csr  = 1'b0;
                new_val = old_val;
            end
        endcase
        // Unmapped addresses drop the write
        wr_en  = ex0_valid & is_csr & hit & ~kill;
        resvld = ex0_valid & is_csr;
        result = old_val;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < exe_pkg::CSR_NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_en) begin
            scratch[idx] <= new_val;
        end
    end

endmodule

//--- rtl/exe.sv
`timescale 1ns/1ps

module exe (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          nuke,
    input  logic                          iss_valid,
    input  exe_pkg::t_uop                 iss_uop,
    input  exe_pkg::t_optype              iss_src2_type,
    input  logic [exe_pkg::PRF_ID_W-1:0]  iss_pdst,
    input  logic                          iss_dst_reg,
    input  logic [exe_pkg::XLEN-1:0]      iss_imm,
    input  logic [exe_pkg::XLEN-1:0]      iss_pc,
    input  logic                          iss_pred_taken,
    input  logic [exe_pkg::XLEN-1:0]      iss_pred_target,
    input  logic [exe_pkg::ROB_ID_W-1:0]  iss_robid,
    input  logic [exe_pkg::XLEN-1:0]      src1_reg_data,
    input  logic [exe_pkg::XLEN-1:0]      src2_reg_data,
    output logic                          br_mispred_valid,
    output logic [exe_pkg::XLEN-1:0]      br_mispred_target,
    output logic [exe_pkg::ROB_ID_W-1:0]  br_mispred_robid,
    output logic                          bpu_train_valid,
    output logic [exe_pkg::XLEN-1:0]      bpu_train_pc,
    output logic                          bpu_train_taken,
    output logic [exe_pkg::XLEN-1:0]      bpu_train_target,
    output logic                          rf_wr_en,
    output logic [exe_pkg::PRF_ID_W-1:0]  rf_wr_pdst,
    output logic [exe_pkg::XLEN-1:0]      rf_wr_data,
    output logic                          complete_valid,
    output logic [exe_pkg::ROB_ID_W-1:0]  complete_robid,
    output logic                          complete_mispred
);

    logic                         ex0_valid;
    exe_pkg::t_uop                ex0_uop;
    exe_pkg::t_optype             ex0_src2_type;
    logic [exe_pkg::XLEN-1:0]     ex0_imm;
    logic [exe_pkg::XLEN-1:0]     ex0_pc;
    logic                         ex0_pred_taken;
    logic [exe_pkg::XLEN-1:0]     ex0_pred_target;
    logic [exe_pkg::ROB_ID_W-1:0] ex0_robid;
    logic [exe_pkg::PRF_ID_W-1:0] ex0_pdst;
    logic                         ex0_dst_reg;
    logic [exe_pkg::XLEN-1:0]     ex0_src1;
    logic [exe_pkg::XLEN-1:0]     ex0_src2;
    logic [exe_pkg::XLEN-1:0]     ex0_result;

    logic                         ex1_valid;
    logic [exe_pkg::ROB_ID_W-1:0] ex1_robid;
    logic [exe_pkg::PRF_ID_W-1:0] ex1_pdst;
    logic                         ex1_dst_reg;
    logic                         ex1_mispred;
    logic [exe_pkg::XLEN-1:0]     ex1_result;

    logic                         alu_resvld;
    logic [exe_pkg::XLEN-1:0]     alu_result;
    logic                         br_resvld;
    logic [exe_pkg::XLEN-1:0]     br_result;
    logic                         br_mispred;
    logic                         br_train_valid;
    logic                         csr_resvld;
    logic [exe_pkg::XLEN-1:0]     csr_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex0_valid <= 1'b0;
            ex1_valid <= 1'b0;
        end else begin
            ex0_valid <= iss_valid & ~nuke;
            ex1_valid <= ex0_valid & ~nuke;
        end
    end

    always_ff @(posedge clk) begin
        ex0_uop         <= iss_uop;
        ex0_src2_type   <= iss_src2_type;
        ex0_imm         <= iss_imm;
        ex0_pc          <= iss_pc;
        ex0_pred_taken  <= iss_pred_taken;
        ex0_pred_target <= iss_pred_target;
        ex0_robid       <= iss_robid;
        ex0_pdst        <= iss_pdst;
        ex0_dst_reg     <= iss_dst_reg;
        ex1_robid       <= ex0_robid;
        ex1_pdst        <= ex0_pdst;
        ex1_dst_reg     <= ex0_dst_reg;
        ex1_mispred     <= br_mispred;
        ex1_result      <= ex0_result;
    end

    // Operand select
    always_comb begin
        ex0_src1 = src1_reg_data;
        case (ex0_src2_type)
            exe_pkg::OP_REG: ex0_src2 = src2_reg_data;
            exe_pkg::OP_IMM: ex0_src2 = ex0_imm;
            default:         ex0_src2 = '0;
        endcase
    end

    int_alu u_int_alu (
        .ex0_valid (ex0_valid),
        .uop       (ex0_uop),
        .src1      (ex0_src1),
        .src2      (ex0_src2),
        .resvld    (alu_resvld),
        .result    (alu_result)
    );

    branch_unit u_branch_unit (
        .ex0_valid      (ex0_valid),
        .uop            (ex0_uop),
        .src1           (ex0_src1),
        .src2           (ex0_src2),
        .imm            (ex0_imm),
        .pc             (ex0_pc),
        .pred_taken     (ex0_pred_taken),
        .pred_target    (ex0_pred_target),
        .resvld         (br_resvld),
        .result         (br_result),
        .mispred        (br_mispred),
        .mispred_target (br_mispred_target),
        .train_valid    (br_train_valid),
        .train_taken    (bpu_train_taken),
        .train_target   (bpu_train_target)
    );

    csr_unit u_csr_unit (
        .clk       (clk),
        .reset     (reset),
        .ex0_valid (ex0_valid),
        .kill      (nuke),
        .uop       (ex0_uop),
        .csr_addr  (ex0_imm[exe_pkg::CSR_ADDR_W-1:0]),
        .src1      (ex0_src1),
        .resvld    (csr_resvld),
        .result    (csr_result)
    );

    // At most one unit claims a uop
    always_comb begin
        ex0_result = (alu_resvld ? alu_result : '0)
                   | (br_resvld  ? br_result  : '0)
                   | (csr_resvld ? csr_result : '0);
    end

    always_comb begin
        br_mispred_valid = br_mispred & ~nuke;
        br_mispred_robid = ex0_robid;
        bpu_train_valid  = br_train_valid & ~nuke;
        bpu_train_pc     = ex0_pc;
    end

    always_comb begin
        complete_valid   = ex1_valid & ~nuke;
        complete_robid   = ex1_robid;
        complete_mispred = complete_valid & ex1_mispred;
        rf_wr_en         = complete_valid & ex1_dst_reg & (ex1_pdst != '0);
        rf_wr_pdst       = ex1_pdst;
        rf_wr_data       = ex1_result;
    end

endmodule

//--- rtl/exe_pkg.sv
package exe_pkg;

    // Datapath widths
    localparam int XLEN        = 32;
    localparam int SHAMT_W     = 5;
    localparam int PRF_ENTRIES = 64;
    localparam int PRF_ID_W    = 6;
    localparam int ROB_ID_W    = 5;

    // CSR space, scratch registers sit at a 4-aligned base
    localparam int CSR_ADDR_W      = 12;
    localparam int CSR_NUM_SCRATCH = 4;
    localparam int CSR_IDX_W       = 2;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_BASE = 12'h340;

    typedef enum logic [4:0] {
        // ALU
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_LUI,
        // Branch and jump
        U_BEQ,
        U_BNE,
        U_BLT,
        U_BGE,
        U_BLTU,
        U_BGEU,
        U_JAL,
        U_JALR,
        // CSR
        U_CSRRW,
        U_CSRRS,
        U_CSRRC,
        U_NOP
    } t_uop;

    // Second operand source
    typedef enum logic [1:0] {
        OP_NONE,
        OP_REG,
        OP_IMM
    } t_optype;

endpackage

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic                      ex0_valid,
    input  exe_pkg::t_uop             uop,
    input  logic [exe_pkg::XLEN-1:0]  src1,
    input  logic [exe_pkg::XLEN-1:0]  src2,
    output logic                      resvld,
    output logic [exe_pkg::XLEN-1:0]  result
);

    logic [exe_pkg::SHAMT_W-1:0] shamt;
    logic                        is_alu;

    always_comb begin
        shamt  = src2[exe_pkg::SHAMT_W-1:0];
        is_alu = 1'b1;
        result = '0;
        case (uop)
            exe_pkg::U_ADD: result = src1 + src2;
            exe_pkg::U_SUB: result = src1 - src2;
            exe_pkg::U_AND: result = src1 & src2;
            exe_pkg::U_OR:  result = src1 | src2;
            exe_pkg::U_XOR: result = src1 ^ src2;
            exe_pkg::U_SLL: result = src1 << shamt;
            exe_pkg::U_SRL: result = src1 >> shamt;
            exe_pkg::U_SRA: result = $unsigned($signed(src1) >>> shamt);
            exe_pkg::U_SLT: begin
                result = {{(exe_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            exe_pkg::U_SLTU: begin
                result = {{(exe_pkg::XLEN-1){1'b0}}, src1 < src2};
            end
            // Immediate arrives already shifted into the upper bits
            exe_pkg::U_LUI: result = src2;
            default: begin
                is_alu = 1'b0;
                result = '0;
            end
        endcase
        resvld = ex0_valid & is_alu;
    end

endmodule

//--- rtl/int_exe_cluster.sv
`timescale 1ns/1ps

module int_exe_cluster (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          nuke,
    input  logic                          iss_valid,
    input  exe_pkg::t_uop                 iss_uop,
    input  exe_pkg::t_optype              iss_src2_type,
    input  logic [exe_pkg::PRF_ID_W-1:0]  iss_psrc1,
    input  logic [exe_pkg::PRF_ID_W-1:0]  iss_psrc2,
    input  logic [exe_pkg::PRF_ID_W-1:0]  iss_pdst,
    input  logic                          iss_dst_reg,
    input  logic [exe_pkg::XLEN-1:0]      iss_imm,
    input  logic [exe_pkg::XLEN-1:0]      iss_pc,
    input  logic                          iss_pred_taken,
    input  logic [exe_pkg::XLEN-1:0]      iss_pred_target,
    input  logic [exe_pkg::ROB_ID_W-1:0]  iss_robid,
    output logic                          br_mispred_valid,
    output logic [exe_pkg::XLEN-1:0]      br_mispred_target,
    output logic [exe_pkg::ROB_ID_W-1:0]  br_mispred_robid,
    output logic                          bpu_train_valid,
    output logic [exe_pkg::XLEN-1:0]      bpu_train_pc,
    output logic                          bpu_train_taken,
    output logic [exe_pkg::XLEN-1:0]      bpu_train_target,
    output logic                          rf_wr_en,
    output logic [exe_pkg::PRF_ID_W-1:0]  rf_wr_pdst,
    output logic [exe_pkg::XLEN-1:0]      rf_wr_data,
    output logic                          complete_valid,
    output logic [exe_pkg::ROB_ID_W-1:0]  complete_robid,
    output logic                          complete_mispred
);

    logic [exe_pkg::XLEN-1:0] src1_reg_data;
    logic [exe_pkg::XLEN-1:0] src2_reg_data;

    // Read data lines up with EX0
    int_prf u_int_prf (
        .clk      (clk),
        .reset    (reset),
        .rd_psrc1 (iss_psrc1),
        .rd_psrc2 (iss_psrc2),
        .wr_en    (rf_wr_en),
        .wr_pdst  (rf_wr_pdst),
        .wr_data  (rf_wr_data),
        .rd_data1 (src1_reg_data),
        .rd_data2 (src2_reg_data)
    );

    exe u_exe (
        .clk               (clk),
        .reset             (reset),
        .nuke              (nuke),
        .iss_valid         (iss_valid),
        .iss_uop           (iss_uop),
        .iss_src2_type     (iss_src2_type),
        .iss_pdst          (iss_pdst),
        .iss_dst_reg       (iss_dst_reg),
        .iss_imm           (iss_imm),
        .iss_pc            (iss_pc),
        .iss_pred_taken    (iss_pred_taken),
        .iss_pred_target   (iss_pred_target),
        .iss_robid         (iss_robid),
        .src1_reg_data     (src1_reg_data),
        .src2_reg_data     (src2_reg_data),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_target (br_mispred_target),
        .br_mispred_robid  (br_mispred_robid),
        .bpu_train_valid   (bpu_train_valid),
        .bpu_train_pc      (bpu_train_pc),
        .bpu_train_taken   (bpu_train_taken),
        .bpu_train_target  (bpu_train_target),
        .rf_wr_en          (rf_wr_en),
        .rf_wr_pdst        (rf_wr_pdst),
        .rf_wr_data        (rf_wr_data),
        .complete_valid    (complete_valid),
        .complete_robid    (complete_robid),
        .complete_mispred  (complete_mispred)
    );

endmodule

//--- rtl/int_prf.sv
`timescale 1ns/1ps

module int_prf (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [exe_pkg::PRF_ID_W-1:0]  rd_psrc1,
    input  logic [exe_pkg::PRF_ID_W-1:0]  rd_psrc2,
    input  logic                          wr_en,
    input  logic [exe_pkg::PRF_ID_W-1:0]  wr_pdst,
    input  logic [exe_pkg::XLEN-1:0]      wr_data,
    output logic [exe_pkg::XLEN-1:0]      rd_data1,
    output logic [exe_pkg::XLEN-1:0]      rd_data2
);

    logic [exe_pkg::XLEN-1:0] regs [exe_pkg::PRF_ENTRIES];

    // Same-cycle write wins over the array contents
    function automatic logic [exe_pkg::XLEN-1:0] read_port(
        input logic [exe_pkg::PRF_ID_W-1:0] psrc
    );
        if (psrc == '0) begin
            return '0;
        end
        if (wr_en && wr_pdst == psrc) begin
            return wr_data;
        end
        return regs[psrc];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < exe_pkg::PRF_ENTRIES; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_pdst != '0) begin
            regs[wr_pdst] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data1 <= read_port(rd_psrc1);
        rd_data2 <= read_port(rd_psrc2);
    end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f list.f --top-module tb_int_exe_cluster -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1

//--- test/tb_int_exe_cluster.sv
`timescale 1ns/1ps

module tb_int_exe_cluster;

    localparam int RESET_CYCLES   = 8;
    localparam int NUM_ISSUES     = 2000;
    localparam int DRAIN_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_ISSUES + RESET_CYCLES + 50;

    logic                          clk;
    logic                          reset;
    logic                          nuke;
    logic                          iss_valid;
    exe_pkg::t_uop                 iss_uop;
    exe_pkg::t_optype              iss_src2_type;
    logic [exe_pkg::PRF_ID_W-1:0]  iss_psrc1, iss_psrc2, iss_pdst;
    logic                          iss_dst_reg;
    logic [exe_pkg::XLEN-1:0]      iss_imm, iss_pc, iss_pred_target;
    logic                          iss_pred_taken;
    logic [exe_pkg::ROB_ID_W-1:0]  iss_robid;
    logic                          br_mispred_valid, bpu_train_valid, bpu_train_taken;
    logic [exe_pkg::XLEN-1:0]      br_mispred_target, bpu_train_pc, bpu_train_target;
    logic [exe_pkg::ROB_ID_W-1:0]  br_mispred_robid, complete_robid;
    logic                          rf_wr_en, complete_valid, complete_mispred;
    logic [exe_pkg::PRF_ID_W-1:0]  rf_wr_pdst;
    logic [exe_pkg::XLEN-1:0]      rf_wr_data;

    // Reference model state
    logic [31:0] mreg [exe_pkg::PRF_ENTRIES];
    logic [31:0] mcsr [4];
    logic             e0_valid = 1'b0;
    exe_pkg::t_uop    e0_uop = exe_pkg::U_NOP;
    exe_pkg::t_optype e0_type = exe_pkg::OP_NONE;
    logic [31:0]      e0_imm = '0, e0_pc = '0, e0_pred_target = '0, e0_a = '0, e0_rb = '0;
    logic             e0_pred_taken = 1'b0, e0_dst = 1'b0;
    logic [4:0]       e0_robid = '0;
    logic [5:0]       e0_pdst = '0;
    logic             e1_valid = 1'b0, e1_dst = 1'b0, e1_mispred = 1'b0;
    logic [4:0]       e1_robid = '0;
    logic [5:0]       e1_pdst = '0;
    logic [31:0]      e1_result = '0;

    // EX0 expectations of the current cycle
    logic        exp_br_valid, exp_taken, exp_mispred, exp_csr_wr;
    logic [31:0] exp_target, exp_mis_target, exp_result, exp_csr_new;
    logic [1:0]  exp_csr_idx;

    int cycle_count = 0;

    int_exe_cluster i_int_exe_cluster (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("SIMULATION FAILED");
            $fatal(1, "timeout: simulation did not finish");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    function automatic logic [31:0] alu_eval(input exe_pkg::t_uop uop, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (uop)
            exe_pkg::U_ADD:  return a + b;
            exe_pkg::U_SUB:  return a - b;
            exe_pkg::U_AND:  return a & b;
            exe_pkg::U_OR:   return a | b;
            exe_pkg::U_XOR:  return a ^ b;
            exe_pkg::U_SLL:  return a << sh;
            exe_pkg::U_SRL:  return a >> sh;
            // Fill vacated upper bits with the sign
            exe_pkg::U_SRA:  return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            exe_pkg::U_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::U_SLTU: return (a < b) ? 32'd1 : 32'd0;
            exe_pkg::U_LUI:  return b;
            default:         return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] read_model(input logic [5:0] id, input logic wr);
        if (id == 0) begin
            return 32'h0;
        end
        if (wr && e1_pdst == id) begin
            return e1_result;
        end
        return mreg[id];
    endfunction

    task automatic compute_ex0();
        logic [31:0] b;
        logic [31:0] old;
        logic [11:0] addr;
        logic        is_br;
        logic        hit;
        case (e0_type)
            exe_pkg::OP_REG: b = e0_rb;
            exe_pkg::OP_IMM: b = e0_imm;
            default:         b = 32'h0;
        endcase
        is_br      = 1'b1;
        exp_target = e0_pc + e0_imm;
        case (e0_uop)
            exe_pkg::U_BEQ:  exp_taken = e0_a == b;
            exe_pkg::U_BNE:  exp_taken = e0_a != b;
            exe_pkg::U_BLT:  exp_taken = $signed(e0_a) < $signed(b);
            exe_pkg::U_BGE:  exp_taken = !($signed(e0_a) < $signed(b));
            exe_pkg::U_BLTU: exp_taken = e0_a < b;
            exe_pkg::U_BGEU: exp_taken = !(e0_a < b);
            exe_pkg::U_JAL:  exp_taken = 1'b1;
            exe_pkg::U_JALR: begin
                exp_taken  = 1'b1;
                exp_target = (e0_a + e0_imm) & 32'hFFFF_FFFE;
            end
            default: begin
                is_br     = 1'b0;
                exp_taken = 1'b0;
            end
        endcase
        exp_br_valid   = e0_valid && is_br;
        exp_mispred    = exp_br_valid && (exp_taken != e0_pred_taken
                         || (exp_taken && exp_target != e0_pred_target));
        exp_mis_target = exp_taken ? exp_target : e0_pc + 4;
        addr        = e0_imm[11:0];
        hit         = addr >= exe_pkg::CSR_SCRATCH_BASE
                      && addr < exe_pkg::CSR_SCRATCH_BASE + 12'd4;
        exp_csr_idx = 2'(addr - exe_pkg::CSR_SCRATCH_BASE);
        old         = hit ? mcsr[exp_csr_idx] : 32'h0;
        exp_csr_wr  = hit;
        case (e0_uop)
            exe_pkg::U_JAL, exe_pkg::U_JALR: begin
                exp_csr_wr = 1'b0;
                exp_result = e0_pc + 4;
            end
            exe_pkg::U_CSRRW: exp_csr_new = e0_a;
            exe_pkg::U_CSRRS: exp_csr_new = old | e0_a;
            exe_pkg::U_CSRRC: exp_csr_new = old & ~e0_a;
            default: begin
                exp_csr_wr = 1'b0;
                exp_result = alu_eval(e0_uop, e0_a, b);
            end
        endcase
        if (e0_uop inside {exe_pkg::U_CSRRW, exe_pkg::U_CSRRS, exe_pkg::U_CSRRC}) begin
            exp_result = old;
        end
    endtask

    task automatic check_outputs();
        logic bv;
        logic cv;
        logic we;
        bv = exp_br_valid && !nuke;
        cv = e1_valid && !nuke;
        we = cv && e1_dst && e1_pdst != 0;
        check_value("bpu_train_valid", 32'(bpu_train_valid), 32'(bv));
        if (bv) begin
            check_value("bpu_train_pc", bpu_train_pc, e0_pc);
            check_value("bpu_train_taken", 32'(bpu_train_taken), 32'(exp_taken));
            check_value("bpu_train_target", bpu_train_target, exp_target);
        end
        check_value("br_mispred_valid", 32'(br_mispred_valid), 32'(exp_mispred && !nuke));
        if (exp_mispred && !nuke) begin
            check_value("br_mispred_target", br_mispred_target, exp_mis_target);
            check_value("br_mispred_robid", 32'(br_mispred_robid), 32'(e0_robid));
        end
        check_value("complete_valid", 32'(complete_valid), 32'(cv));
        check_value("complete_mispred", 32'(complete_mispred), 32'(cv && e1_mispred));
        if (cv) begin
            check_value("complete_robid", 32'(complete_robid), 32'(e1_robid));
        end
        check_value("rf_wr_en", 32'(rf_wr_en), 32'(we));
        if (we) begin
            check_value("rf_wr_pdst", 32'(rf_wr_pdst), 32'(e1_pdst));
            check_value("rf_wr_data", rf_wr_data, e1_result);
        end
    endtask

    task automatic check_idle();
        check_value("complete_valid", 32'(complete_valid), 32'h0);
        check_value("rf_wr_en", 32'(rf_wr_en), 32'h0);
        check_value("br_mispred_valid", 32'(br_mispred_valid), 32'h0);
        check_value("bpu_train_valid", 32'(bpu_train_valid), 32'h0);
    endtask

    // Register and CSR writes at the end of the cycle before the pipe shifts
    task automatic advance_model();
        logic wr;
        wr = e1_valid && !nuke && e1_dst && e1_pdst != 0;
        if (e0_valid && !nuke && exp_csr_wr) begin
            mcsr[exp_csr_idx] = exp_csr_new;
        end
        e1_valid       = e0_valid && !nuke;
        e1_robid       = e0_robid;
        e1_dst         = e0_dst;
        e1_mispred     = exp_mispred;
        e0_valid       = iss_valid && !nuke;
        e0_a           = read_model(iss_psrc1, wr);
        e0_rb          = read_model(iss_psrc2, wr);
        if (wr) begin
            mreg[e1_pdst] = e1_result;
        end
        e1_pdst        = e0_pdst;
        e1_result      = exp_result;
        e0_uop         = iss_uop;
        e0_type        = iss_src2_type;
        e0_imm         = iss_imm;
        e0_pc          = iss_pc;
        e0_pred_taken  = iss_pred_taken;
        e0_pred_target = iss_pred_target;
        e0_robid       = iss_robid;
        e0_pdst        = iss_pdst;
        e0_dst         = iss_dst_reg;
    endtask

    task automatic drive_inputs(input bit active);
        exe_pkg::t_uop uop;
        logic [31:0]   imm;
        logic [31:0]   pc;
        uop = exe_pkg::t_uop'(5'($urandom_range(0, 22)));
        imm = $urandom;
        pc  = $urandom & 32'hFFFF_FFFC;
        // Two of the six addresses fall outside the scratch set
        if (uop inside {exe_pkg::U_CSRRW, exe_pkg::U_CSRRS, exe_pkg::U_CSRRC}) begin
            imm[11:0] = exe_pkg::CSR_SCRATCH_BASE + 12'($urandom_range(0, 5));
        end
        iss_valid       <= active && $urandom_range(0, 99) < 80;
        nuke            <= active && $urandom_range(0, 99) < 3;
        iss_uop         <= uop;
        iss_src2_type   <= exe_pkg::t_optype'(2'($urandom_range(0, 2)));
        iss_psrc1       <= exe_pkg::PRF_ID_W'($urandom_range(0, 15));
        iss_psrc2       <= exe_pkg::PRF_ID_W'($urandom_range(0, 15));
        iss_pdst        <= exe_pkg::PRF_ID_W'($urandom_range(0, 15));
        iss_dst_reg     <= $urandom_range(0, 9) < 8;
        iss_imm         <= imm;
        iss_pc          <= pc;
        iss_pred_taken  <= $urandom_range(0, 1) == 1;
        iss_pred_target <= ($urandom_range(0, 1) == 1) ? pc + imm : $urandom;
        iss_robid       <= exe_pkg::ROB_ID_W'($urandom);
    endtask

    initial begin
        void'($urandom(91));
        for (int i = 0; i < exe_pkg::PRF_ENTRIES; i++) begin
            mreg[i] = 32'h0;
        end
        for (int i = 0; i < 4; i++) begin
            mcsr[i] = 32'h0;
        end
        reset <= 1'b1;
        drive_inputs(1'b0);
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        reset <= 1'b0;
        drive_inputs(1'b1);
        for (int cyc = 0; cyc < NUM_ISSUES + DRAIN_CYCLES; cyc++) begin
            @(negedge clk);
            compute_ex0();
            check_outputs();
            @(posedge clk);
            advance_model();
            drive_inputs(cyc + 1 < NUM_ISSUES);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
